// File: design/usbRxPkg.sv
package usbRxPkg;

    // ========================================================================
    // Stream types
    // ========================================================================

    // One line sample from the differential front end
    typedef struct packed {
        // Line level, 1 means J
        logic level;
        // Differential pair was valid
        logic valid;
        // End of packet seen on this sample
        logic eop;
    } lineSample_t;

    // One decoded bit after NRZI and stuffing removal
    typedef struct packed {
        logic bitVal;
        // Cleared for a stuffed bit
        logic isData;
        // Invalid sample or stuffing violation
        logic err;
    } decBit_t;

    // One received byte
    typedef struct packed {
        logic [7:0] data;
    } rxByte_t;

    // Packet status, valid with the done pulse
    typedef struct packed {
        logic keep;
    } rxStatus_t;

    // Control towards the serial CRC register
    typedef struct packed {
        // Load all ones and latch the width
        logic clear;
        logic useCrc16;
        logic inBit;
        logic inValid;
    } crcCtl_t;

    // ========================================================================
    // Protocol constants
    // ========================================================================

    // SYNC as assembled LSB first
    localparam logic [7:0] SYNC_BYTE = 8'h80;
    // Low PID bits of the data packets
    localparam logic [1:0] PID_TYPE_DATA = 2'b11;
    // A zero is stuffed after this many ones
    localparam logic [2:0] STUFF_RUN = 3'd6;

    localparam logic [4:0] CRC5_POLY = 5'h05;
    localparam logic [4:0] CRC5_RESIDUAL = 5'b01100;
    localparam logic [15:0] CRC16_POLY = 16'h8005;
    localparam logic [15:0] CRC16_RESIDUAL = 16'h800D;

    // Byte buffer depth
    localparam int RX_FIFO_DEPTH = 4;
    // Trailing CRC16 bytes kept back from the stream
    localparam int CRC16_HOLD = 2;

endpackage

// File: design/nrziDecoder.sv
`timescale 1ns/1ps

module nrziDecoder (
    input  logic                  clk12_i,
    input  logic                  rstN_i,
    input  usbRxPkg::lineSample_t sample_i,
    input  logic                  restart_i,
    output logic                  bit_o,
    output logic                  bitErr_o,
    output logic                  eop_o
);

    // Level of the previous sample, idle is J
    logic prevLevel;

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prevLevel <= 1'b1;
            bit_o <= 1'b1;
            bitErr_o <= 1'b0;
            eop_o <= 1'b0;
        end else begin
            // No transition decodes to a one
            // Line level carries no data during EOP
            bit_o <= sample_i.eop || (sample_i.level == prevLevel);
            // Flags move with the decoded bit
            bitErr_o <= !sample_i.valid;
            eop_o <= sample_i.eop;
            // Line returns to J after the packet
            if (restart_i || sample_i.eop) begin
                prevLevel <= 1'b1;
            end else begin
                prevLevel <= sample_i.level;
            end
        end
    end

endmodule

// File: design/bitUnstuffer.sv
`timescale 1ns/1ps

module bitUnstuffer (
    input  logic              clk12_i,
    input  logic              rstN_i,
    input  logic              bit_i,
    input  logic              bitErr_i,
    input  logic              restart_i,
    output usbRxPkg::decBit_t dec_o
);
    import usbRxPkg::*;

    // Consecutive ones seen so far
    logic [2:0] runCnt;
    // Current bit follows a full run of ones
    logic stuffed;

    assign stuffed = (runCnt == STUFF_RUN);

    // Bit itself passes straight through
    assign dec_o.bitVal = bit_i;
    // Stuffed bit is no data
    assign dec_o.isData = !stuffed;
    // A one where the stuffed zero belongs is a violation
    assign dec_o.err = bitErr_i || (stuffed && bit_i);

    // ========================================================================
    // Run counter
    // ========================================================================

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            runCnt <= 3'd0;
        end else if (restart_i || stuffed || !bit_i) begin
            // Zero, stuffed bit or new packet starts a fresh run
            runCnt <= 3'd0;
        end else begin
            runCnt <= runCnt + 3'd1;
        end
    end

    // Run length stays within the stuffing limit
    assert property (@(posedge clk12_i) disable iff (!rstN_i)
        runCnt <= STUFF_RUN);

endmodule

// File: design/usbCrcCheck.sv
`timescale 1ns/1ps

module usbCrcCheck (
    input  logic              clk12_i,
    input  logic              rstN_i,
    input  usbRxPkg::crcCtl_t ctl_i,
    output logic              crcOk_o
);
    import usbRxPkg::*;

    // Shared register, CRC5 uses the low five bits
    logic [15:0] crcReg;
    // Width chosen at clear
    logic use16;

    logic fb5;
    logic fb16;
    logic [4:0] crc5Next;
    logic [15:0] crc16Next;

    // ========================================================================
    // Serial update, bits in line order
    // ========================================================================

    // Feedback from the top bit of each width
    assign fb5 = crcReg[4] ^ ctl_i.inBit;
    assign fb16 = crcReg[15] ^ ctl_i.inBit;

    assign crc5Next = {crcReg[3:0], 1'b0} ^ (fb5 ? CRC5_POLY : 5'h00);
    assign crc16Next = {crcReg[14:0], 1'b0} ^ (fb16 ? CRC16_POLY : 16'h0000);

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            crcReg <= '1;
            use16 <= 1'b0;
        end else if (ctl_i.clear) begin
            // Seed all ones
            crcReg <= '1;
            use16 <= ctl_i.useCrc16;
        end else if (ctl_i.inValid) begin
            if (use16) begin
                crcReg <= crc16Next;
            end else begin
                // Upper bits idle in CRC5 mode
                crcReg <= {crcReg[15:5], crc5Next};
            end
        end
    end

    // Received CRC included leaves the fixed residual
    assign crcOk_o = use16 ? (crcReg == CRC16_RESIDUAL)
                           : (crcReg[4:0] == CRC5_RESIDUAL);

endmodule

// File: design/rxPacketEngine.sv
`timescale 1ns/1ps

module rxPacketEngine (
    input  logic              clk12_i,
    input  logic              rstN_i,
    input  usbRxPkg::decBit_t dec_i,
    input  logic              eop_i,
    input  logic              crcOk_i,
    output usbRxPkg::crcCtl_t crcCtl_o,
    output logic              restart_o,
    output logic              pushValid_o,
    output usbRxPkg::rxByte_t pushByte_o,
    output logic              useCrc16_o,
    output logic              pktEnd_o,
    output logic              pktDrop_o,
    input  logic              bufAccept_i
);
    import usbRxPkg::*;

    typedef enum logic [1:0] {
        WAIT_SYNC,
        GET_PID,
        WAIT_EOP,
        RESTART
    } rxState_t;

    rxState_t state;

    // Bits enter at the top, so the byte ends up LSB first
    logic [7:0] shiftReg;
    logic [2:0] bitCnt;
    // Eighth data bit entered on the last edge
    logic byteFull;

    // Error tracking for the current packet
    logic sigErr;
    logic pidErr;
    // CRC state after the last complete byte
    logic crcOkLatch;
    logic needCrc16;

    logic inPacket;
    logic dataBit;
    logic syncHit;
    logic pidOk;
    logic pidIsData;
    logic byteLost;
    logic crcFeed;
    logic eopHit;
    logic pidBad;
    logic crcBad;
    logic verdict;

    assign inPacket = (state == GET_PID) || (state == WAIT_EOP);
    assign dataBit = dec_i.isData && !eop_i;

    // Compare against the value the shift is about to hold
    assign syncHit = (state == WAIT_SYNC) && !eop_i
                     && ({dec_i.bitVal, shiftReg[7:1]} == SYNC_BYTE);

    // Upper nibble carries the complement of the lower one
    assign pidOk = (shiftReg[7:4] == ~shiftReg[3:0]);
    assign pidIsData = (shiftReg[1:0] == PID_TYPE_DATA);

    // ========================================================================
    // Byte push towards the buffer
    // ========================================================================

    assign pushValid_o = byteFull && inPacket;
    assign pushByte_o = '{data: shiftReg};
    // PID byte goes out with its own type
    assign useCrc16_o = (state == GET_PID) ? pidIsData : needCrc16;
    assign byteLost = pushValid_o && !bufAccept_i;

    // ========================================================================
    // CRC control
    // ========================================================================

    // Bits after the PID feed the CRC
    assign crcFeed = dataBit && ((state == GET_PID && byteFull) || state == WAIT_EOP);

    // Cleared while the PID arrives, width latched on the last clear
    // Type bits still sit one place up before the eighth bit lands
    assign crcCtl_o.clear = (state == GET_PID) && !byteFull;
    assign crcCtl_o.useCrc16 = (state == GET_PID) && (shiftReg[2:1] == PID_TYPE_DATA);
    assign crcCtl_o.inBit = dec_i.bitVal && crcFeed;
    assign crcCtl_o.inValid = crcFeed;

    // ========================================================================
    // Verdict at EOP
    // ========================================================================

    assign eopHit = eop_i && inPacket;
    // EOP inside the PID means an incomplete PID
    assign pidBad = (state == GET_PID) ? !(byteFull && pidOk) : pidErr;
    // Last byte may complete in the EOP cycle itself
    assign crcBad = (byteFull && state == WAIT_EOP) ? !crcOk_i : !crcOkLatch;
    // A partial byte also drops the packet
    assign verdict = sigErr || byteLost || pidBad || crcBad || (bitCnt != 3'd0);

    assign restart_o = (state == RESTART);

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= WAIT_SYNC;
            shiftReg <= 8'hFF;
            bitCnt <= 3'd0;
            byteFull <= 1'b0;
            sigErr <= 1'b0;
            pidErr <= 1'b0;
            crcOkLatch <= 1'b1;
            needCrc16 <= 1'b0;
            pktEnd_o <= 1'b0;
            pktDrop_o <= 1'b0;
        end else begin
            pktEnd_o <= eopHit;
            pktDrop_o <= eopHit && verdict;
            byteFull <= 1'b0;
            case (state)
                WAIT_SYNC: begin
                    // Every bit shifts while hunting, stuffing not yet active
                    if (!eop_i) begin
                        shiftReg <= {dec_i.bitVal, shiftReg[7:1]};
                    end
                    if (syncHit) begin
                        // Align the byte boundary to the PID
                        state <= GET_PID;
                        bitCnt <= 3'd0;
                        sigErr <= 1'b0;
                        pidErr <= 1'b0;
                    end
                end
                GET_PID, WAIT_EOP: begin
                    if (dataBit) begin
                        shiftReg <= {dec_i.bitVal, shiftReg[7:1]};
                        bitCnt <= bitCnt + 3'd1;
                        byteFull <= (bitCnt == 3'd7);
                    end
                    sigErr <= sigErr || (dec_i.err && !eop_i) || byteLost;
                    // PID complete
                    if (byteFull && state == GET_PID) begin
                        pidErr <= !pidOk;
                        needCrc16 <= pidIsData;
                        state <= WAIT_EOP;
                    end
                    if (byteFull && state == WAIT_EOP) begin
                        crcOkLatch <= crcOk_i;
                    end
                    if (eop_i) begin
                        state <= RESTART;
                    end
                end
                RESTART: begin
                    // Idle pattern so stale bits never match SYNC
                    shiftReg <= 8'hFF;
                    // Handshakes carry no CRC and must pass
                    crcOkLatch <= 1'b1;
                    state <= WAIT_SYNC;
                end
                default: begin
                    state <= WAIT_SYNC;
                end
            endcase
        end
    end

    // A byte completes only between SYNC and EOP
    assert property (@(posedge clk12_i) disable iff (!rstN_i)
        byteFull |-> (state inside {GET_PID, WAIT_EOP}));

endmodule

// File: design/rxByteBuffer.sv
`timescale 1ns/1ps

module rxByteBuffer #(
    parameter int DEPTH = 4
) (
    input  logic                clk12_i,
    input  logic                rstN_i,
    input  logic                pushValid_i,
    input  usbRxPkg::rxByte_t   pushByte_i,
    input  logic                useCrc16_i,
    input  logic                pktEnd_i,
    input  logic                pktDrop_i,
    output logic                bufAccept_o,
    output usbRxPkg::rxByte_t   rxByte_o,
    output logic                rxValid_o,
    input  logic                rxReady_i,
    output logic                rxDone_o,
    output usbRxPkg::rxStatus_t rxStatus_o
);
    import usbRxPkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef enum logic {
        COLLECT,
        DRAIN
    } bufState_t;

    rxByte_t mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] afterPop;
    logic [CNT_W-1:0] flushCnt;
    bufState_t state;

    // Current packet ends in two CRC bytes
    logic pktCrc16;
    logic dropFlag;
    // A byte was refused in this packet
    logic lostFlag;

    logic push;
    logic pop;
    logic lose;
    logic done;

    assign bufAccept_o = (count < CNT_W'(DEPTH));
    assign push = pushValid_i && bufAccept_o;
    assign lose = pushValid_i && !bufAccept_o;

    // Head waits until it cannot be a CRC byte
    assign rxValid_o = (count != '0)
                       && (!pktCrc16 || count > CNT_W'(CRC16_HOLD) || state == DRAIN);
    assign pop = rxValid_o && rxReady_i;
    assign rxByte_o = mem[rdPtr];

    // CRC bytes are the newest entries, drop them from the tail
    assign afterPop = count - CNT_W'(pop);
    assign flushCnt = !(pktEnd_i && pktCrc16) ? '0
                    : (afterPop > CNT_W'(CRC16_HOLD)) ? CNT_W'(CRC16_HOLD) : afterPop;

    // ========================================================================
    // Storage
    // ========================================================================

    always_ff @(posedge clk12_i) begin
        if (push) begin
            mem[wrPtr] <= pushByte_i;
        end
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            pktCrc16 <= 1'b0;
        end else begin
            wrPtr <= wrPtr + PTR_W'(push) - PTR_W'(flushCnt);
            rdPtr <= rdPtr + PTR_W'(pop);
            count <= afterPop + CNT_W'(push) - flushCnt;
            // Each byte brings its packet's CRC kind
            if (pushValid_i) begin
                pktCrc16 <= useCrc16_i;
            end
        end
    end

    // ========================================================================
    // Packet status
    // ========================================================================

    // Done once the last byte of the packet has left
    assign done = (state == DRAIN) && (count == '0);
    assign rxDone_o = done;
    assign rxStatus_o.keep = !(dropFlag || lostFlag);

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= COLLECT;
            dropFlag <= 1'b0;
            lostFlag <= 1'b0;
        end else begin
            lostFlag <= (lostFlag && !done) || lose;
            case (state)
                COLLECT: begin
                    if (pktEnd_i) begin
                        dropFlag <= pktDrop_i;
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (done) begin
                        state <= COLLECT;
                    end
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

    // Pointers agree that the head holds a byte
    assert property (@(posedge clk12_i) disable iff (!rstN_i)
        pop |-> (wrPtr != rdPtr || count == CNT_W'(DEPTH)));

    // An offered byte stays put until taken, also across the flush
    assert property (@(posedge clk12_i) disable iff (!rstN_i)
        (rxValid_o && !rxReady_i) |=> (rxValid_o && $stable(rxByte_o)));

endmodule

// File: design/usbRx.sv
`timescale 1ns/1ps

module usbRx (
    input  logic                  clk12_i,
    input  logic                  rstN_i,
    input  usbRxPkg::lineSample_t lineSample_i,
    output usbRxPkg::rxByte_t     rxByte_o,
    output logic                  rxValid_o,
    input  logic                  rxReady_i,
    output logic                  rxDone_o,
    output usbRxPkg::rxStatus_t   rxStatus_o
);
    import usbRxPkg::*;

    // Decoder to unstuffer
    logic decBit;
    logic decErr;
    logic decEop;
    logic restart;
    decBit_t dec;

    // Engine and CRC register
    crcCtl_t crcCtl;
    logic crcOk;

    // Engine to buffer
    logic pushValid;
    rxByte_t pushByte;
    logic useCrc16;
    logic pktEnd;
    logic pktDrop;
    logic bufAccept;

    // ========================================================================
    // Bit level
    // ========================================================================

    nrziDecoder nrziDecoder_inst (
        .clk12_i  (clk12_i),
        .rstN_i   (rstN_i),
        .sample_i (lineSample_i),
        .restart_i(restart),
        .bit_o    (decBit),
        .bitErr_o (decErr),
        .eop_o    (decEop)
    );

    bitUnstuffer bitUnstuffer_inst (
        .clk12_i  (clk12_i),
        .rstN_i   (rstN_i),
        .bit_i    (decBit),
        .bitErr_i (decErr),
        .restart_i(restart),
        .dec_o    (dec)
    );

    // ========================================================================
    // Packet level
    // ========================================================================

    // EOP bypasses the combinational unstuffer
    rxPacketEngine rxPacketEngine_inst (
        .clk12_i    (clk12_i),
        .rstN_i     (rstN_i),
        .dec_i      (dec),
        .eop_i      (decEop),
        .crcOk_i    (crcOk),
        .crcCtl_o   (crcCtl),
        .restart_o  (restart),
        .pushValid_o(pushValid),
        .pushByte_o (pushByte),
        .useCrc16_o (useCrc16),
        .pktEnd_o   (pktEnd),
        .pktDrop_o  (pktDrop),
        .bufAccept_i(bufAccept)
    );

    usbCrcCheck usbCrcCheck_inst (
        .clk12_i(clk12_i),
        .rstN_i (rstN_i),
        .ctl_i  (crcCtl),
        .crcOk_o(crcOk)
    );

    rxByteBuffer #(
        .DEPTH(RX_FIFO_DEPTH)
    ) rxByteBuffer_inst (
        .clk12_i    (clk12_i),
        .rstN_i     (rstN_i),
        .pushValid_i(pushValid),
        .pushByte_i (pushByte),
        .useCrc16_i (useCrc16),
        .pktEnd_i   (pktEnd),
        .pktDrop_i  (pktDrop),
        .bufAccept_o(bufAccept),
        .rxByte_o   (rxByte_o),
        .rxValid_o  (rxValid_o),
        .rxReady_i  (rxReady_i),
        .rxDone_o   (rxDone_o),
        .rxStatus_o (rxStatus_o)
    );

endmodule

// File: dv/usbRxTb.sv
`timescale 1ns/1ps

module usbRxTb;
    import usbRxPkg::*;

    logic clk12;
    logic rstN;
    lineSample_t lineSample;
    rxByte_t rxByte;
    logic rxValid;
    logic rxReady;
    logic rxDone;
    rxStatus_t rxStatus;

    // Bytes on the wire after SYNC, PID first
    logic [7:0] txBytes[$];
    // Bytes the stream should deliver
    logic [7:0] expBytes[$];
    // Bytes taken from the stream
    rxByte_t rxBytes[$];
    rxStatus_t gotStatus;
    logic sendDone;

    // Encoder state for the packet on the line
    logic lineLevel;
    int sampleIdx;
    int invalidIdx;

    logic [31:0] lcgState;
    int checkCnt;
    int valueErrs;
    int otherErrs;

    usbRx usbRx_inst (
        .clk12_i     (clk12),
        .rstN_i      (rstN),
        .lineSample_i(lineSample),
        .rxByte_o    (rxByte),
        .rxValid_o   (rxValid),
        .rxReady_i   (rxReady),
        .rxDone_o    (rxDone),
        .rxStatus_o  (rxStatus)
    );

    // 4 ns period
    always #2 clk12 = ~clk12;

    function automatic logic [7:0] lcgByte();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        // Upper bits have the longer period
        return lcgState[23:16];
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic checkByte(input string name, input rxByte_t expV, input rxByte_t actV);
        checkCnt++;
        if (actV !== expV) begin
            valueErrs++;
            $display("[ERROR] %s: expected %02h, actual %02h", name, expV.data, actV.data);
        end
    endtask

    task automatic checkStatus(input string name, input rxStatus_t expV,
                               input rxStatus_t actV);
        checkCnt++;
        if (actV !== expV) begin
            valueErrs++;
            $display("[ERROR] %s: expected keep %0b, actual keep %0b",
                     name, expV.keep, actV.keep);
        end
    endtask

    task automatic expectKeep(input string name, input logic keep);
        rxStatus_t expS;
        expS.keep = keep;
        checkStatus(name, expS, gotStatus);
    endtask

    // ========================================================================
    // Packet building
    // ========================================================================

    task automatic startPacket(input logic [7:0] pid);
        txBytes.delete();
        txBytes.push_back(pid);
    endtask

    // Payload with long runs of ones across byte borders
    task automatic addPayload(input int n);
        logic [7:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcgByte();
            if (i % 2 == 0) begin
                txBytes.push_back(r | 8'hF0);
            end else begin
                txBytes.push_back(r | 8'h0F);
            end
        end
    endtask

    // Token field is 11 bits, CRC5 fills the top of the second byte
    task automatic appendCrc5();
        logic [7:0] b1;
        logic [7:0] b2;
        logic [10:0] field;
        logic [4:0] crc;
        logic fb;
        b1 = txBytes[1];
        b2 = txBytes[2];
        field = {b2[2:0], b1};
        crc = 5'h1F;
        for (int i = 0; i < 11; i++) begin
            fb = crc[4] ^ field[i];
            crc = {crc[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
        end
        // Inverted remainder, MSB first on the line
        for (int i = 0; i < 5; i++) begin
            b2[3 + i] = ~crc[4 - i];
        end
        txBytes[2] = b2;
    endtask

    // CRC16 covers everything after the PID
    task automatic appendCrc16();
        logic [15:0] crc;
        logic [7:0] cur;
        logic [7:0] lo;
        logic [7:0] hi;
        logic fb;
        crc = 16'hFFFF;
        for (int k = 1; k < txBytes.size(); k++) begin
            cur = txBytes[k];
            for (int j = 0; j < 8; j++) begin
                fb = crc[15] ^ cur[j];
                crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
            end
        end
        for (int j = 0; j < 8; j++) begin
            lo[j] = ~crc[15 - j];
            hi[j] = ~crc[7 - j];
        end
        txBytes.push_back(lo);
        txBytes.push_back(hi);
    endtask

    task automatic expectFirst(input int n);
        expBytes.delete();
        for (int i = 0; i < n; i++) begin
            expBytes.push_back(txBytes[i]);
        end
    endtask

    // ========================================================================
    // Line driver
    // ========================================================================

    task automatic setSample(input logic level, input logic valid, input logic eop);
        lineSample.level = level;
        lineSample.valid = valid;
        lineSample.eop = eop;
    endtask

    task automatic driveIdle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk12);
            setSample(1'b1, 1'b1, 1'b0);
        end
    endtask

    // NRZI, a zero toggles the line
    task automatic driveBit(input logic b);
        @(negedge clk12);
        if (!b) begin
            lineLevel = ~lineLevel;
        end
        setSample(lineLevel, sampleIdx != invalidIdx, 1'b0);
        sampleIdx++;
    endtask

    task automatic sendPacket(input logic skipStuff, input int invalidAt);
        logic bitQ[$];
        logic [7:0] cur;
        int run;
        logic skipped;
        sendDone = 1'b0;
        invalidIdx = invalidAt;
        sampleIdx = 0;
        lineLevel = 1'b1;
        driveIdle(8);
        // SYNC is seven zeros and a one
        for (int i = 0; i < 7; i++) begin
            bitQ.push_back(1'b0);
        end
        bitQ.push_back(1'b1);
        for (int k = 0; k < txBytes.size(); k++) begin
            cur = txBytes[k];
            for (int j = 0; j < 8; j++) begin
                bitQ.push_back(cur[j]);
            end
        end
        run = 0;
        skipped = 1'b0;
        for (int i = 0; i < bitQ.size(); i++) begin
            driveBit(bitQ[i]);
            if (bitQ[i]) begin
                run++;
            end else begin
                run = 0;
            end
            if (run == 6) begin
                // Leaving out one stuffed zero makes a run of seven
                if (skipStuff && !skipped) begin
                    skipped = 1'b1;
                end else begin
                    driveBit(1'b0);
                end
                run = 0;
            end
        end
        @(negedge clk12);
        setSample(1'b1, 1'b1, 1'b1);
        driveIdle(4);
        sendDone = 1'b1;
    endtask

    // ========================================================================
    // Stream collector
    // ========================================================================

    // Ready modes: 0 always, 1 LCG toggled, 2 low until the packet is sent
    task automatic collectPacket(input string name, input int readyMode);
        int waitCnt;
        logic gotDone;
        logic [7:0] r;
        rxBytes.delete();
        waitCnt = 0;
        gotDone = 1'b0;
        while (!gotDone) begin
            @(negedge clk12);
            // Ready for the coming rise
            case (readyMode)
                1: begin
                    r = lcgByte();
                    rxReady = (r[1:0] != 2'b00);
                end
                2: begin
                    rxReady = sendDone;
                end
                default: begin
                    rxReady = 1'b1;
                end
            endcase
            // Valid is settled mid cycle, transfer happens at the next rise
            if (rxValid && rxReady) begin
                rxBytes.push_back(rxByte);
            end
            if (rxDone) begin
                gotStatus = rxStatus;
                gotDone = 1'b1;
            end
            waitCnt++;
            if (waitCnt > 2000) begin
                $display("%s: no done pulse within 2000 cycles", name);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    endtask

    task automatic runPacket(input string name, input int readyMode,
                             input logic skipStuff, input int invalidAt);
        $display("Test: %s", name);
        fork
            sendPacket(skipStuff, invalidAt);
            collectPacket(name, readyMode);
        join
    endtask

    task automatic compareStream(input string name);
        rxByte_t expB;
        int n;
        n = rxBytes.size();
        if (n != expBytes.size()) begin
            otherErrs++;
            $display("%s: stream delivered %0d bytes instead of %0d", name, n, expBytes.size());
            if (expBytes.size() < n) begin
                n = expBytes.size();
            end
        end
        for (int i = 0; i < n; i++) begin
            expB.data = expBytes[i];
            checkByte(name, expB, rxBytes[i]);
        end
    endtask

    // Received bytes must appear in the sent order, gaps allowed
    task automatic compareSubsequence(input string name);
        int j;
        checkCnt++;
        j = 0;
        for (int i = 0; i < rxBytes.size(); i++) begin
            while (j < expBytes.size() && expBytes[j] != rxBytes[i].data) begin
                j++;
            end
            if (j == expBytes.size()) begin
                otherErrs++;
                $display("%s: byte %02h is out of order or was never sent",
                         name, rxBytes[i].data);
                break;
            end
            j++;
        end
        if (rxBytes.size() == 0 || rxBytes.size() >= expBytes.size()) begin
            otherErrs++;
            $display("%s: %0d of %0d bytes arrived, expected a partial stream",
                     name, rxBytes.size(), expBytes.size());
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic testHandshake();
        startPacket(8'hD2);
        expectFirst(1);
        runPacket("ack", 0, 1'b0, -1);
        compareStream("ack");
        expectKeep("ack", 1'b1);
    endtask

    task automatic testToken();
        startPacket(8'h69);
        txBytes.push_back(lcgByte());
        txBytes.push_back(lcgByte());
        appendCrc5();
        expectFirst(3);
        runPacket("token", 0, 1'b0, -1);
        compareStream("token");
        expectKeep("token", 1'b1);
    endtask

    task automatic testData();
        startPacket(8'hC3);
        addPayload(8);
        appendCrc16();
        expectFirst(txBytes.size() - 2);
        runPacket("data0", 0, 1'b0, -1);
        compareStream("data0");
        expectKeep("data0", 1'b1);
    endtask

    task automatic testBadCrc();
        logic [7:0] last;
        startPacket(8'h4B);
        addPayload(4);
        appendCrc16();
        last = txBytes.pop_back();
        txBytes.push_back(last ^ 8'h10);
        expectFirst(txBytes.size() - 2);
        runPacket("badCrc", 0, 1'b0, -1);
        compareStream("badCrc");
        expectKeep("badCrc", 1'b0);
    endtask

    task automatic testFailures();
        // PID nibbles not complementary
        startPacket(8'hC7);
        addPayload(2);
        appendCrc16();
        runPacket("badPid", 0, 1'b0, -1);
        expectKeep("badPid", 1'b0);
        // Run of seven ones inside the payload
        startPacket(8'hC3);
        txBytes.push_back(8'hFF);
        txBytes.push_back(8'hFF);
        txBytes.push_back(8'h00);
        appendCrc16();
        runPacket("stuffErr", 0, 1'b1, -1);
        expectKeep("stuffErr", 1'b0);
        // Sample 20 lies in the token field
        startPacket(8'h69);
        txBytes.push_back(lcgByte());
        txBytes.push_back(lcgByte());
        appendCrc5();
        runPacket("invalidSample", 0, 1'b0, 20);
        expectKeep("invalidSample", 1'b0);
    endtask

    task automatic testBackPressure();
        startPacket(8'hC3);
        addPayload(10);
        appendCrc16();
        expectFirst(txBytes.size() - 2);
        runPacket("readyToggle", 1, 1'b0, -1);
        compareStream("readyToggle");
        expectKeep("readyToggle", 1'b1);
        // Twelve bytes on the wire against a four entry buffer
        startPacket(8'hC3);
        addPayload(9);
        appendCrc16();
        expectFirst(txBytes.size() - 2);
        runPacket("readyLow", 2, 1'b0, -1);
        compareSubsequence("readyLow");
        expectKeep("readyLow", 1'b0);
    endtask

    initial begin
        clk12 = 1'b0;
        rstN = 1'b0;
        setSample(1'b1, 1'b1, 1'b0);
        rxReady = 1'b0;
        sendDone = 1'b0;
        lineLevel = 1'b1;
        sampleIdx = 0;
        invalidIdx = -1;
        lcgState = 32'd11386;
        checkCnt = 0;
        valueErrs = 0;
        otherErrs = 0;
        repeat (4) @(posedge clk12);
        @(negedge clk12);
        rstN = 1'b1;

        testHandshake();
        testToken();
        testData();
        testBadCrc();
        testFailures();
        testBackPressure();

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checkCnt, valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
design/usbRxPkg.sv
design/nrziDecoder.sv
design/bitUnstuffer.sv
design/usbCrcCheck.sv
design/rxPacketEngine.sv
design/rxByteBuffer.sv
design/usbRx.sv
dv/usbRxTb.sv

// File: Bender.yml
package:
  name: usb_rx

sources:
  - files:
      - design/usbRxPkg.sv
      - design/nrziDecoder.sv
      - design/bitUnstuffer.sv
      - design/usbCrcCheck.sv
      - design/rxPacketEngine.sv
      - design/rxByteBuffer.sv
      - design/usbRx.sv
  - target: test
    files:
      - dv/usbRxTb.sv
